// ==== files.f ====
hw/noc_pkg.sv
hw/cam_pkg.sv
hw/cam_capture.sv
hw/word_fifo.sv
hw/cam_packetizer.sv
hw/camera_tile.sv
test/tb_camera_tile.sv

// ==== hw/cam_capture.sv ====
// Camera capture
// Samples the parallel sensor bus in clk, packs bytes into 32-bit words and
// tags each word with line end, line number and frame number
`timescale 1ns/1ps

module cam_capture (
   input  logic            clk,
   input  logic            rst_i,
   input  logic            pclk_i,
   input  logic            href_i,
   input  logic            vsync_i,
   input  cam_pkg::pixel_t d_i,
   input  logic            full_i,
   output logic            push_o,
   output cam_pkg::word_t  word_o,
   output logic            last_o,
   output cam_pkg::line_t  line_o,
   output cam_pkg::frame_t frame_o,
   output logic            overflow_o
);

   localparam int BCNT_W = $clog2(cam_pkg::BYTES_PER_WORD);
   localparam logic [BCNT_W-1:0] BCNT_LAST = BCNT_W'(cam_pkg::BYTES_PER_WORD - 1);

   logic pclk_q, href_q, vsync_q; // Sampled sensor lines
   logic pclk_d, href_d, vsync_d; // One clk older
   cam_pkg::pixel_t d_q;

   cam_pkg::capture_state_t state;
   logic [BCNT_W-1:0] byte_cnt;   // Next byte slot in acc
   cam_pkg::word_t    acc;        // Word being packed, or the held complete word
   logic              hold_valid; // acc holds a complete word not yet pushed
   cam_pkg::line_t    line_cnt;
   cam_pkg::frame_t   frame_cnt;

   logic pclk_rise;
   logic href_fall;
   logic vsync_rise;
   logic take;
   logic line_end;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         {pclk_q, href_q, vsync_q} <= 3'b000;
         {pclk_d, href_d, vsync_d} <= 3'b000;
      end else begin
         {pclk_q, href_q, vsync_q} <= {pclk_i, href_i, vsync_i};
         {pclk_d, href_d, vsync_d} <= {pclk_q, href_q, vsync_q};
      end
   end

   always_ff @(posedge clk) d_q <= d_i; // Sampled together with pclk_q

   assign pclk_rise  = pclk_q & ~pclk_d;
   assign href_fall  = href_d & ~href_q;
   assign vsync_rise = vsync_q & ~vsync_d;
   // Byte strobe, ignored until the first frame starts
   assign take     = pclk_rise & href_q & (state != cam_pkg::CAP_IDLE);
   assign line_end = href_fall & (state == cam_pkg::CAP_LINE);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state <= cam_pkg::CAP_IDLE;
      end else if (vsync_rise) begin
         state <= cam_pkg::CAP_GAP; // New frame, also restarts a broken one
      end else begin
         case (state)
            cam_pkg::CAP_GAP:  if (href_q) state <= cam_pkg::CAP_LINE;
            cam_pkg::CAP_LINE: if (href_fall) state <= cam_pkg::CAP_GAP;
            default:           state <= state;
         endcase
      end
   end

   // Packing control, line and frame counters
   always_ff @(posedge clk) begin
      if (rst_i) begin
         byte_cnt   <= '0;
         hold_valid <= 1'b0;
         line_cnt   <= '0;
         frame_cnt  <= '1; // First VSYNC brings it to frame 0
         push_o     <= 1'b0;
         last_o     <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         push_o     <= 1'b0;
         overflow_o <= overflow_o | (push_o & full_i); // Sticky, buffer drops it
         if (vsync_rise) begin
            byte_cnt   <= '0;
            hold_valid <= 1'b0;
            line_cnt   <= '0;
            frame_cnt  <= frame_cnt + 1'b1;
         end else if (take) begin
            byte_cnt <= byte_cnt + 1'b1; // Wraps after the fourth byte
            if (hold_valid) begin
               push_o <= 1'b1; // More bytes follow, so not the last word
               last_o <= 1'b0;
            end
            hold_valid <= (byte_cnt == BCNT_LAST);
         end else if (line_end) begin
            byte_cnt   <= '0;
            hold_valid <= 1'b0;
            if (hold_valid || byte_cnt != '0) begin
               push_o   <= 1'b1; // Held full word or zero-padded partial
               last_o   <= 1'b1;
               line_cnt <= line_cnt + 1'b1;
            end
         end
      end
   end

   // Word payload
   always_ff @(posedge clk) begin
      if (take) begin
         if (byte_cnt == '0) begin
            acc <= cam_pkg::word_t'(d_q); // Clears the high bytes for padding
         end else begin
            acc[byte_cnt*cam_pkg::PIXEL_WIDTH +: cam_pkg::PIXEL_WIDTH] <= d_q;
         end
      end
      if ((take && hold_valid) || line_end) word_o <= acc;
      line_o  <= line_cnt;  // Sampled at the push edge
      frame_o <= frame_cnt;
   end

endmodule

// ==== hw/cam_packetizer.sv ====
// Camera packetizer
// Cuts the buffered words into NoC packets, one header flit and up to
// PKT_WORDS payload flits each, under valid/ready back-pressure
`timescale 1ns/1ps

module cam_packetizer #(
   parameter noc_pkg::tile_id_t ID        = 5'd3,
   parameter noc_pkg::tile_id_t DEST_ID   = 5'd0,
   parameter int                PKT_WORDS = 4
) (
   input  logic                            clk,
   input  logic                            rst_i,
   input  logic [cam_pkg::ENTRY_WIDTH-1:0] data_i,
   input  logic                            empty_i,
   input  logic                            noc_out_ready_i,
   output logic                            pop_o,
   output noc_pkg::flit_t                  noc_out_flit_o,
   output logic                            noc_out_valid_o
);

   localparam int CNT_W = $clog2(PKT_WORDS + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PKT_WORDS - 1);

   typedef enum logic {
      PK_HEAD, // Header of the next packet
      PK_BODY  // Payload flits
   } pk_state_t;

   pk_state_t        state;
   logic [CNT_W-1:0] word_cnt; // Payload flits sent in this packet

   cam_pkg::word_t      entry_word;
   logic                entry_last;
   cam_pkg::line_t      entry_line;
   cam_pkg::frame_t     entry_frame;
   noc_pkg::flit_data_t header;
   logic                pkt_end;
   logic                xfer;

   // Head entry fields
   assign entry_word  = data_i[cam_pkg::ENTRY_WORD_LSB +: cam_pkg::WORD_WIDTH];
   assign entry_last  = data_i[cam_pkg::ENTRY_LAST_BIT];
   assign entry_line  = data_i[cam_pkg::ENTRY_LINE_LSB +: cam_pkg::LINE_WIDTH];
   assign entry_frame = data_i[cam_pkg::ENTRY_FRAME_LSB +: cam_pkg::FRAME_WIDTH];

   always_comb begin
      header = '0;
      header[noc_pkg::HDR_DEST_LSB +: $bits(noc_pkg::tile_id_t)] = DEST_ID;
      header[noc_pkg::HDR_CLASS_LSB +: $bits(noc_pkg::class_t)]  = noc_pkg::CLASS_CAMERA;
      header[noc_pkg::HDR_SRC_LSB +: $bits(noc_pkg::tile_id_t)]  = ID;
      header[noc_pkg::HDR_FRAME_LSB +: cam_pkg::FRAME_WIDTH]     = entry_frame;
      header[noc_pkg::HDR_LINE_LSB +: cam_pkg::LINE_WIDTH]       = entry_line;
   end

   // Line end or full packet closes it
   assign pkt_end = entry_last | (word_cnt == CNT_LAST);

   // Head entry stays put until popped, so flit and valid hold while stalled
   assign noc_out_valid_o = ~empty_i;
   assign xfer            = noc_out_valid_o & noc_out_ready_i;
   assign pop_o           = xfer & (state == PK_BODY); // Header does not consume

   always_comb begin
      if (state == PK_HEAD) begin
         noc_out_flit_o = {noc_pkg::FLIT_HEAD, header};
      end else if (pkt_end) begin
         noc_out_flit_o = {noc_pkg::FLIT_LAST, entry_word};
      end else begin
         noc_out_flit_o = {noc_pkg::FLIT_PAYLOAD, entry_word};
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state    <= PK_HEAD;
         word_cnt <= '0;
      end else if (xfer) begin
         case (state)
            PK_HEAD: begin
               state    <= PK_BODY;
               word_cnt <= '0;
            end
            PK_BODY: begin
               if (pkt_end) begin
                  state <= PK_HEAD; // Rest of a long line gets a new header
               end else begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            default: state <= PK_HEAD;
         endcase
      end
   end

endmodule

// ==== hw/cam_pkg.sv ====
// Camera capture definitions
// Pixel, word and counter types, buffer entry layout and capture FSM states
package cam_pkg;

   localparam int PIXEL_WIDTH    = 8;
   localparam int WORD_WIDTH     = 32;
   localparam int LINE_WIDTH     = 11;
   localparam int FRAME_WIDTH    = 8;
   localparam int BYTES_PER_WORD = WORD_WIDTH / PIXEL_WIDTH;

   typedef logic [PIXEL_WIDTH-1:0] pixel_t; // One sensor byte
   typedef logic [WORD_WIDTH-1:0]  word_t;  // First line byte in bits 7:0
   typedef logic [LINE_WIDTH-1:0]  line_t;
   typedef logic [FRAME_WIDTH-1:0] frame_t; // Wraps

   // Buffer entry {word, last, line, frame}
   localparam int ENTRY_FRAME_LSB = 0;
   localparam int ENTRY_LINE_LSB  = FRAME_WIDTH;
   localparam int ENTRY_LAST_BIT  = FRAME_WIDTH + LINE_WIDTH;
   localparam int ENTRY_WORD_LSB  = ENTRY_LAST_BIT + 1;
   localparam int ENTRY_WIDTH     = ENTRY_WORD_LSB + WORD_WIDTH; // 52

   typedef enum logic [1:0] {
      CAP_IDLE, // No VSYNC seen yet
      CAP_LINE, // HREF high
      CAP_GAP   // Between lines
   } capture_state_t;

endpackage

// ==== hw/camera_tile.sv ====
// Camera tile
// Sensor capture, word buffer and packetizer driving one NoC tile link
`timescale 1ns/1ps

module camera_tile #(
   parameter noc_pkg::tile_id_t ID         = 5'd3,
   parameter noc_pkg::tile_id_t DEST_ID    = 5'd0,
   parameter int                PKT_WORDS  = 4,
   parameter int                FIFO_DEPTH = 16
) (
   input  logic            clk,
   input  logic            rst_i,
   input  logic            pclk_i,
   input  logic            href_i,
   input  logic            vsync_i,
   input  cam_pkg::pixel_t d_i,
   output noc_pkg::flit_t  noc_out_flit_o,
   output logic            noc_out_valid_o,
   input  logic            noc_out_ready_i,
   output logic            overflow_o
);

   logic                            cap_push;
   cam_pkg::word_t                  cap_word;
   logic                            cap_last;
   cam_pkg::line_t                  cap_line;
   cam_pkg::frame_t                 cap_frame;
   logic                            fifo_full;
   logic                            fifo_empty;
   logic                            fifo_pop;
   logic [cam_pkg::ENTRY_WIDTH-1:0] fifo_head; // Head entry, FWFT

   cam_capture u_capture (
      .clk        (clk),
      .rst_i      (rst_i),
      .pclk_i     (pclk_i),
      .href_i     (href_i),
      .vsync_i    (vsync_i),
      .d_i        (d_i),
      .full_i     (fifo_full),
      .push_o     (cap_push),
      .word_o     (cap_word),
      .last_o     (cap_last),
      .line_o     (cap_line),
      .frame_o    (cap_frame),
      .overflow_o (overflow_o)
   );

   word_fifo #(
      .WIDTH      (cam_pkg::ENTRY_WIDTH),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk     (clk),
      .rst_i   (rst_i),
      .push_i  (cap_push),
      .data_i  ({cap_word, cap_last, cap_line, cap_frame}), // Entry layout
      .pop_i   (fifo_pop),
      .data_o  (fifo_head),
      .empty_o (fifo_empty),
      .full_o  (fifo_full)
   );

   cam_packetizer #(
      .ID        (ID),
      .DEST_ID   (DEST_ID),
      .PKT_WORDS (PKT_WORDS)
   ) u_packetizer (
      .clk             (clk),
      .rst_i           (rst_i),
      .data_i          (fifo_head),
      .empty_i         (fifo_empty),
      .noc_out_ready_i (noc_out_ready_i),
      .pop_o           (fifo_pop),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o)
   );

endmodule

// ==== hw/noc_pkg.sv ====
// NoC tile link definitions
// Flit layout, flit type codes and header field positions of the
// single-channel link between a tile and its mesh router
package noc_pkg;

   localparam int FLIT_TYPE_WIDTH = 2;
   localparam int FLIT_DATA_WIDTH = 32;
   localparam int FLIT_WIDTH      = FLIT_TYPE_WIDTH + FLIT_DATA_WIDTH; // Type on top

   typedef logic [FLIT_WIDTH-1:0]      flit_t;
   typedef logic [FLIT_TYPE_WIDTH-1:0] flit_type_t;
   typedef logic [FLIT_DATA_WIDTH-1:0] flit_data_t;
   typedef logic [4:0]                 tile_id_t;   // Mesh tile address
   typedef logic [2:0]                 class_t;     // Packet class

   // Flit type codes
   localparam flit_type_t FLIT_HEAD    = 2'b10;
   localparam flit_type_t FLIT_PAYLOAD = 2'b00;
   localparam flit_type_t FLIT_LAST    = 2'b01; // Payload that closes the packet

   localparam class_t CLASS_CAMERA = 3'd3;

   // Header data fields, LSB of each
   // dest 31:27, class 26:24, src 23:19, frame 18:11, line 10:0
   localparam int HDR_DEST_LSB  = 27;
   localparam int HDR_CLASS_LSB = 24;
   localparam int HDR_SRC_LSB   = 19;
   localparam int HDR_FRAME_LSB = 11;
   localparam int HDR_LINE_LSB  = 0;

endpackage

// ==== hw/word_fifo.sv ====
// Word buffer
// First-word-fall-through FIFO between the capture and the packetizer,
// pushes into a full buffer are dropped
`timescale 1ns/1ps

module word_fifo #(
   parameter int WIDTH      = 52,
   parameter int FIFO_DEPTH = 16 // Power of two
) (
   input  logic             clk,
   input  logic             rst_i,
   input  logic             push_i,
   input  logic [WIDTH-1:0] data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] data_o,
   output logic             empty_o,
   output logic             full_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   logic [WIDTH-1:0] mem [FIFO_DEPTH];
   logic [AW:0]      wr_ptr; // Extra MSB tells full from empty
   logic [AW:0]      rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o; // Guard only

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr[AW-1:0]] <= data_i;
   end

   // Head entry always visible
   assign data_o = mem[rd_ptr[AW-1:0]];

   assign empty_o = (wr_ptr == rd_ptr);
   // Same slot, one lap apart
   assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the camera tile testbench with Verilator and runs it
# Exit status is nonzero when the build fails or the testbench stops on an error
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_camera_tile -o tb_camera_tile \
   && ./obj_dir/tb_camera_tile \
   || { echo "simulation run failed"; exit 1; }

// ==== test/tb_camera_tile.sv ====
// Camera tile testbench
// Random sensor frames and random link ready, checked against a flit model
// built from the bytes driven, then an overflow phase with the link stalled
`timescale 1ns/1ps

module tb_camera_tile;

   localparam int PKT_WORDS = 4;
   localparam int N_FRAMES  = 4;
   localparam noc_pkg::tile_id_t EXP_DEST  = 5'd0;
   localparam noc_pkg::tile_id_t EXP_SRC   = 5'd3;
   localparam logic [2:0]        EXP_CLASS = 3'd3;

   logic clk;
   logic rst_i;
   logic pclk_i;
   logic href_i;
   logic vsync_i;
   cam_pkg::pixel_t d_i;
   noc_pkg::flit_t noc_out_flit_o;
   logic noc_out_valid_o;
   logic noc_out_ready_i;
   logic overflow_o;

   int seed;
   int limit_cycles = 0;     // Watchdog off until stimulus is known
   int cycle_cnt    = 0;
   int drained      = 0;     // Flits seen after the overflow
   bit rand_ready   = 1'b0;
   bit drain_phase  = 1'b0;
   bit stall_seen   = 1'b0;  // Valid without ready on the last edge
   noc_pkg::flit_t stall_flit;    // Flit left waiting on that edge
   int frame_lines[N_FRAMES];
   cam_pkg::pixel_t stim_bytes[$]; // Every line byte, in drive order
   int line_start[$];
   int line_len[$];
   int line_gap[$];               // Idle PCLK cycles before the line
   noc_pkg::flit_t exp_q[$];      // Flits expected in the random phase
   noc_pkg::flit_t drain_q[$];    // Flits the overflow phase may show
   noc_pkg::flit_t exp_flit;

   camera_tile UUT (
      .clk             (clk),
      .rst_i           (rst_i),
      .pclk_i          (pclk_i),
      .href_i          (href_i),
      .vsync_i         (vsync_i),
      .d_i             (d_i),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .overflow_o      (overflow_o)
   );

   always #10 clk = ~clk; // 20 ns period

   task automatic check_flit(input string name, input noc_pkg::flit_t got,
                             input noc_pkg::flit_t exp);
      if (got !== exp) begin
         $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH time=%0t %s expected=%b got=%b", $time, name, exp, got);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   // Drained flits may skip model flits but never reorder them
   task automatic find_drained_flit(input noc_pkg::flit_t got);
      bit found;
      found = 1'b0;
      while (!found && drain_q.size() != 0) found = (drain_q.pop_front() == got);
      if (!found) begin
         $display("Drained flit %h at %0t is not in order among the expected flits", got, $time);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   // Stores one line of random bytes
   task automatic append_line(input int len, input int gap);
      logic [31:0] rnd;
      line_start.push_back(stim_bytes.size());
      line_len.push_back(len);
      line_gap.push_back(gap);
      for (int bi = 0; bi < len; bi++) begin
         rnd = $random(seed);
         stim_bytes.push_back(rnd[7:0]);
      end
   endtask

   // Flit model of one line: pack four bytes per word, cut packets of PKT_WORDS
   task automatic add_line_model(input int li, input cam_pkg::frame_t fnum,
                                 input cam_pkg::line_t lnum, input bit to_drain);
      int n_words;
      int cnt;
      int pos;
      cam_pkg::word_t w;
      noc_pkg::flit_t f;
      noc_pkg::flit_type_t t;
      n_words = (line_len[li] + 3) / 4;
      cnt     = 0;
      for (int wi = 0; wi < n_words; wi++) begin
         if (cnt == 0) begin
            f = {noc_pkg::FLIT_HEAD, EXP_DEST, EXP_CLASS, EXP_SRC, fnum, lnum};
            if (to_drain) drain_q.push_back(f);
            else exp_q.push_back(f);
         end
         w = '0; // Short last word stays zero-padded
         for (int k = 0; k < 4; k++) begin
            pos = 4 * wi + k;
            if (pos < line_len[li]) w[8*k +: 8] = stim_bytes[line_start[li] + pos];
         end
         if (wi == n_words - 1 || cnt == PKT_WORDS - 1) begin
            t   = noc_pkg::FLIT_LAST; // Line end or full packet
            cnt = 0;
         end else begin
            t   = noc_pkg::FLIT_PAYLOAD;
            cnt = cnt + 1;
         end
         if (to_drain) drain_q.push_back({t, w});
         else exp_q.push_back({t, w});
      end
   endtask

   // One PCLK period of 4 clk, sensor lines change while PCLK is low
   task automatic pclk_cycle(input logic href, input logic vsync, input cam_pkg::pixel_t d);
      @(negedge clk);
      pclk_i  = 1'b0;
      href_i  = href;
      vsync_i = vsync;
      d_i     = d;
      @(negedge clk);
      @(negedge clk);
      pclk_i = 1'b1; // Sensor byte taken here
      @(negedge clk);
   endtask

   task automatic drive_vsync();
      repeat (2) pclk_cycle(1'b0, 1'b1, 8'h00);
      repeat (2) pclk_cycle(1'b0, 1'b0, 8'h00);
   endtask

   task automatic drive_line(input int li);
      repeat (line_gap[li]) pclk_cycle(1'b0, 1'b0, 8'h00);
      for (int bi = 0; bi < line_len[li]; bi++) begin
         pclk_cycle(1'b1, 1'b0, stim_bytes[line_start[li] + bi]);
      end
      pclk_cycle(1'b0, 1'b0, 8'h00); // HREF fall ends the line
   endtask

   // Link ready about 70 percent of the time
   always @(negedge clk) begin
      if (rand_ready) noc_out_ready_i = ({$random(seed)} % 10) < 7;
   end

   // Flit monitor, values stable since the last falling edge
   always @(posedge clk) begin
      if (!rst_i && noc_out_valid_o && noc_out_ready_i) begin
         if (drain_phase) begin
            find_drained_flit(noc_out_flit_o);
            check_flag("overflow_o", overflow_o, 1'b1); // Sticky
            drained = drained + 1;
         end else if (exp_q.size() == 0) begin
            $display("Unexpected flit %h at %0t after all model flits", noc_out_flit_o, $time);
            $display("Checks failed");
            $fatal(1);
         end else begin
            exp_flit = exp_q.pop_front();
            check_flit("noc_out_flit_o", noc_out_flit_o, exp_flit);
            check_flag("overflow_o", overflow_o, 1'b0);
         end
      end
   end

   // A stalled flit stays on the link unchanged until taken
   always @(posedge clk) begin
      if (!rst_i && stall_seen) begin
         check_flag("noc_out_valid_o", noc_out_valid_o, 1'b1);
         check_flit("noc_out_flit_o", noc_out_flit_o, stall_flit);
      end
      stall_seen = !rst_i && noc_out_valid_o && !noc_out_ready_i;
      stall_flit = noc_out_flit_o;
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
         $display("simulation timed out before all flits arrived");
         $display("Checks failed");
         $fatal(1);
      end
   end

   initial begin
      int li;
      int fill_li;
      clk             = 1'b0;
      rst_i           = 1'b1;
      pclk_i          = 1'b0;
      href_i          = 1'b0;
      vsync_i         = 1'b0;
      d_i             = 8'h00;
      noc_out_ready_i = 1'b0;
      seed            = 7378;
      li              = 0;
      // Random frames, 2 to 5 lines of 1 to 40 bytes each
      for (int fr = 0; fr < N_FRAMES; fr++) begin
         frame_lines[fr] = 2 + ({$random(seed)} % 4);
         for (int ln = 0; ln < frame_lines[fr]; ln++) begin
            append_line(1 + ({$random(seed)} % 40), 2 + ({$random(seed)} % 5));
            add_line_model(li, cam_pkg::frame_t'(fr), cam_pkg::line_t'(ln), 1'b0);
            li = li + 1;
         end
      end
      // Overflow phase, 16 words fill the buffer, then a 40-byte line
      fill_li = li;
      append_line(64, 2);
      add_line_model(fill_li, 8'd3, cam_pkg::line_t'(frame_lines[3]), 1'b1);
      append_line(40, 2);
      add_line_model(fill_li + 1, 8'd3, cam_pkg::line_t'(frame_lines[3] + 1), 1'b1);
      limit_cycles = stim_bytes.size() * 8 + 2000;

      repeat (2) @(negedge clk);
      check_flag("noc_out_valid_o", noc_out_valid_o, 1'b0); // Low out of reset
      check_flag("overflow_o", overflow_o, 1'b0);
      rst_i      = 1'b0;
      rand_ready = 1'b1;
      li         = 0;
      for (int fr = 0; fr < N_FRAMES; fr++) begin
         drive_vsync();
         for (int ln = 0; ln < frame_lines[fr]; ln++) begin
            drive_line(li);
            li = li + 1;
         end
      end
      repeat (2) pclk_cycle(1'b0, 1'b0, 8'h00);
      while (exp_q.size() != 0) @(negedge clk); // All model flits seen
      check_flag("overflow_o", overflow_o, 1'b0);

      rand_ready = 1'b0;
      @(negedge clk);
      noc_out_ready_i = 1'b0; // Link stalled through both lines
      drive_line(fill_li);
      drive_line(fill_li + 1);
      repeat (4) pclk_cycle(1'b0, 1'b0, 8'h00);
      check_flag("overflow_o", overflow_o, 1'b1);
      drain_phase = 1'b1;
      @(negedge clk);
      noc_out_ready_i = 1'b1;
      while (noc_out_valid_o) @(negedge clk); // Buffer drained
      check_flag("overflow_o", overflow_o, 1'b1);
      if (drained == 0) begin
         $display("No flit drained from the full buffer after the overflow");
         $display("Checks failed");
         $fatal(1);
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule
